/* filelist.f */
verilog/riscPkg.sv
verilog/registerFile.sv
verilog/aluAdder.sv
verilog/rfAluDatapath.sv
verilog/controlUnit.sv
verilog/multicycleCore.sv
testbench/multicycleCoreTb.sv

/* testbench/multicycleCoreTb.sv */
`timescale 1ns/1ps

module multicycleCoreTb;
    import riscPkg::*;

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 16;
    localparam int numRandom   = 400;
    // Init and two OUT sweeps plus at most an LD and an OUT after each random op
    localparam int maxInstr    = 3 * numRegs + 3 * numRandom;
    localparam int cycleLimit  = resetCycles + 5 * maxInstr + 2000;

    logic   clk;
    logic   arstN;
    logic   instrValid;
    instr_t instrIn;
    word_t  memRdata;
    word_t  memAddr;
    word_t  memWdata;
    logic   memWe;
    word_t  outR;
    logic   outValid;
    logic   busy;
    logic   cFlag;
    logic   zFlag;
    logic   nFlag;

    // Memory seen by the DUT, and the reference copy
    word_t envMem   [256];
    word_t modelMem [256];
    // Reference registers and flags
    word_t modelRegs [numRegs];
    logic  mC;
    logic  mZ;
    logic  mN;

    logic [31:0] rngState;
    int          errors;
    int          checks;
    int          issued;
    int          cycles = 0;

    multicycleCore dut (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instrIn    (instrIn),
        .memRdata   (memRdata),
        .memAddr    (memAddr),
        .memWdata   (memWdata),
        .memWe      (memWe),
        .outR       (outR),
        .outValid   (outValid),
        .busy       (busy),
        .cFlag      (cFlag),
        .zFlag      (zFlag),
        .nFlag      (nFlag)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Combinational read and write on the strobe
    assign memRdata = envMem[memAddr[7:0]];

    always @(posedge clk) begin
        if (memWe) begin
            envMem[memAddr[7:0]] <= memWdata;
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout, the run went past %0d cycles", cycleLimit);
            $display("Issued %0d instructions, checks %0d, errors %0d", issued, checks, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Both bytes taken from the full 8-bit address
    function automatic word_t fillWord(input logic [7:0] addr);
        return {addr ^ 8'hc3, ~addr};
    endfunction

    function automatic instr_t encode(input opcode_t op, input regAddr_t rd,
                                      input logic [7:0] low);
        return {op, rd, low};
    endfunction

    task automatic checkValue(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // ISA rules on the reference state
    task automatic applyModel(input instr_t ins);
        opcode_t     op;
        regAddr_t    rd;
        word_t       a;
        word_t       b;
        logic [16:0] wide;
        op   = ins[15:11];
        rd   = ins[10:8];
        a    = modelRegs[ins[7:5]];
        b    = modelRegs[ins[4:2]];
        wide = '0;
        case (op)
            opAdd:  wide = {1'b0, a} + {1'b0, b};
            opAddc: wide = {1'b0, a} + {1'b0, b} + {16'd0, mC};
            // Subtract is A plus inverted B plus one
            opSub:  wide = {1'b0, a} + {1'b0, ~b} + 17'd1;
            opSubc: wide = {1'b0, a} + {1'b0, ~b} + {16'd0, mC};
            opAddi: wide = {1'b0, a} + {12'd0, ins[4:0]};
            opCmp:  wide = {1'b0, a} + {1'b0, ~b} + 17'd1;
            opLi:   modelRegs[rd] = {8'h00, ins[7:0]};
            opLui:  modelRegs[rd] = {ins[7:0], modelRegs[rd][7:0]};
            opLd:   modelRegs[rd] = modelMem[a[7:0]];
            opSt:   modelMem[a[7:0]] = modelRegs[rd];
            default: ;
        endcase
        // Arithmetic group sets flags and all but CMP write rd
        if (op <= opCmp) begin
            mC = wide[16];
            mZ = (wide[15:0] == 16'd0);
            mN = wide[15];
            if (op != opCmp) begin
                modelRegs[rd] = wide[15:0];
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One instruction from issue to idle
    ////////////////////////////////////////////////////////////

    task automatic runInstr(input instr_t ins);
        opcode_t op;
        word_t   expA;
        word_t   expD;
        int      busyCycles;
        int      weCount;
        int      outCount;
        op         = ins[15:11];
        expA       = modelRegs[ins[7:5]];
        expD       = modelRegs[ins[10:8]];
        busyCycles = 0;
        weCount    = 0;
        outCount   = 0;
        @(posedge clk);
        while (busy) @(posedge clk);
        #1;
        instrValid = 1'b1;
        instrIn    = ins;
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        issued++;
        applyModel(ins);
        // One sample per busy cycle on the falling edge
        @(negedge clk);
        while (busy && busyCycles < 8) begin
            busyCycles++;
            if (memWe) begin
                weCount++;
                checkValue($sformatf("memWe cycle #%0d", issued), 2, busyCycles);
                checkValue($sformatf("memAddr #%0d", issued), expA, memAddr);
                checkValue($sformatf("memWdata #%0d", issued), expD, memWdata);
            end
            if (outValid) begin
                outCount++;
                checkValue($sformatf("outValid cycle #%0d", issued), 2, busyCycles);
                checkValue($sformatf("outR #%0d", issued), expA, outR);
            end
            @(negedge clk);
        end
        checkValue($sformatf("busy cycles #%0d", issued), 3, busyCycles);
        checkValue($sformatf("memWe pulses #%0d", issued), word_t'(op == opSt), weCount);
        checkValue($sformatf("outValid pulses #%0d", issued), word_t'(op == opOut), outCount);
        // Flags packed as C Z N
        checkValue($sformatf("flags #%0d", issued), {13'd0, mC, mZ, mN},
                   {13'd0, cFlag, zFlag, nFlag});
    endtask

    task automatic outAll();
        for (int i = 0; i < numRegs; i++) begin
            runInstr(encode(opOut, 3'd0, {regAddr_t'(i), 5'd0}));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        instr_t      ins;
        opcode_t     op;
        arstN      = 1'b0;
        instrValid = 1'b0;
        instrIn    = '0;
        errors     = 0;
        checks     = 0;
        issued     = 0;
        rngState   = 32'h719e;
        mC         = 1'b0;
        mZ         = 1'b0;
        mN         = 1'b0;
        for (int i = 0; i < 256; i++) begin
            envMem[i]   = fillWord(i[7:0]);
            modelMem[i] = fillWord(i[7:0]);
        end
        for (int i = 0; i < numRegs; i++) begin
            modelRegs[i] = '0;
        end

        repeat (resetCycles) @(posedge clk);
        #1;
        checkValue("busy in reset", 0, busy);
        checkValue("memWe in reset", 0, memWe);
        checkValue("outValid in reset", 0, outValid);
        checkValue("flags in reset", 0, {13'd0, cFlag, zFlag, nFlag});
        arstN = 1'b1;

        // Every register reads zero after reset
        outAll();

        // Even registers by LI, odd ones by LUI
        for (int i = 0; i < numRegs; i++) begin
            rngState = xorshift(rngState);
            op = (i % 2 == 1) ? opLui : opLi;
            runInstr(encode(op, regAddr_t'(i), rngState[7:0]));
        end

        for (int k = 0; k < numRandom; k++) begin
            rngState = xorshift(rngState);
            r = rngState;
            // Mostly valid codes, a few from the whole range
            if (r[31:28] == 4'd0) begin
                op = r[15:11];
            end else begin
                op = opcode_t'(r[4:0] % 11);
            end
            ins = {op, r[26:16]};
            runInstr(ins);
            // Read back each store through another register
            if (op == opSt) begin
                runInstr(encode(opLd, ins[10:8] + 3'd1, {ins[7:5], 5'd0}));
                runInstr(encode(opOut, 3'd0, {ins[10:8] + 3'd1, 5'd0}));
            end
        end

        outAll();

        $display("Issued %0d instructions, checks %0d, errors %0d", issued, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* verilog/aluAdder.sv */
`timescale 1ns/1ps

// Adder/subtractor with flag outputs
module aluAdder (
    input  riscPkg::word_t a,
    input  riscPkg::word_t b,
    input  logic           subtract,
    input  logic           useCarry,
    input  logic           pswC,
    output riscPkg::word_t sum,
    output logic           cOut,
    output logic           z,
    output logic           n
);
    import riscPkg::*;

    // B after optional inversion
    word_t               bOp;
    // Carry into bit zero
    logic                cIn;
    // One extra bit for carry out
    logic [dataWidth:0]  fullSum;

    ////////////////////////////////////////////////////////////
    // Operand preparation
    ////////////////////////////////////////////////////////////

    // Two's complement subtract is A + ~B + 1
    assign bOp = subtract ? ~b : b;

    // Chained ops take the stored carry
    // Otherwise carry-in follows the operation
    always_comb begin
        if (useCarry) begin
            cIn = pswC;
        end else begin
            cIn = subtract;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sum and flags
    ////////////////////////////////////////////////////////////

    assign fullSum = {1'b0, a} + {1'b0, bOp} + {{dataWidth{1'b0}}, cIn};

    assign sum  = fullSum[dataWidth-1:0];
    // Carry from the top bit
    assign cOut = fullSum[dataWidth];
    // Zero over the whole result
    assign z    = (fullSum[dataWidth-1:0] == '0);
    // Sign bit
    assign n    = fullSum[dataWidth-1];

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/1ps

// Instruction register, sequencer, decode and status flags
module controlUnit (
    input  logic            clk,
    input  logic            arstN,
    input  logic            instrValid,
    input  riscPkg::instr_t instrIn,
    input  logic            sumC,
    input  logic            sumZ,
    input  logic            sumN,
    output riscPkg::instr_t instr,
    output logic            rbSelRd,
    output logic            operandImm,
    output logic            liUpper,
    output logic            idExeLoad,
    output logic            useCarry,
    output logic            subtract,
    output logic            wbMem,
    output logic            wbLi,
    output logic            wbEn,
    output logic            pswC,
    output logic            busy,
    output logic            memWe,
    output logic            outValid,
    output logic            cFlag,
    output logic            zFlag,
    output logic            nFlag
);
    import riscPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;
    opcode_t    opcode;

    // Decoded per opcode, before state gating
    logic writesRd;
    logic setsFlags;
    logic isStore;
    logic isOut;

    // Status register
    logic cReg;
    logic zReg;
    logic nReg;

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    // Accept only from idle, then three fixed steps
    always_comb begin
        nextState = state;
        case (state)
            stIdle:      if (instrValid) nextState = stDecode;
            stDecode:    nextState = stExecute;
            stExecute:   nextState = stWriteback;
            stWriteback: nextState = stIdle;
            default:     nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            instr <= '0;
        end else begin
            state <= nextState;
            // Pulses while busy are dropped
            if (state == stIdle && instrValid) begin
                instr <= instrIn;
            end
        end
    end

    assign busy = (state != stIdle);

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    assign opcode = instr[opMsb:opLsb];

    always_comb begin
        // Unknown codes fall through as no-ops
        rbSelRd    = 1'b0;
        operandImm = 1'b0;
        liUpper    = 1'b0;
        useCarry   = 1'b0;
        subtract   = 1'b0;
        wbMem      = 1'b0;
        wbLi       = 1'b0;
        writesRd   = 1'b0;
        setsFlags  = 1'b0;
        isStore    = 1'b0;
        isOut      = 1'b0;
        case (opcode)
            opAdd: begin
                writesRd  = 1'b1;
                setsFlags = 1'b1;
            end
            opAddc: begin
                useCarry  = 1'b1;
                writesRd  = 1'b1;
                setsFlags = 1'b1;
            end
            opSub: begin
                subtract  = 1'b1;
                writesRd  = 1'b1;
                setsFlags = 1'b1;
            end
            opSubc: begin
                subtract  = 1'b1;
                useCarry  = 1'b1;
                writesRd  = 1'b1;
                setsFlags = 1'b1;
            end
            opAddi: begin
                operandImm = 1'b1;
                writesRd   = 1'b1;
                setsFlags  = 1'b1;
            end
            // Compare is a subtract with no register write
            opCmp: begin
                subtract  = 1'b1;
                setsFlags = 1'b1;
            end
            opLi: begin
                wbLi     = 1'b1;
                writesRd = 1'b1;
            end
            // Needs rd on port B for its low byte
            opLui: begin
                rbSelRd  = 1'b1;
                liUpper  = 1'b1;
                wbLi     = 1'b1;
                writesRd = 1'b1;
            end
            opLd: begin
                wbMem    = 1'b1;
                writesRd = 1'b1;
            end
            opSt: begin
                rbSelRd = 1'b1;
                isStore = 1'b1;
            end
            opOut:   isOut = 1'b1;
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Strobes gated by state
    ////////////////////////////////////////////////////////////

    assign idExeLoad = (state == stDecode);
    assign memWe     = (state == stExecute) && isStore;
    assign outValid  = (state == stExecute) && isOut;
    assign wbEn      = (state == stWriteback) && writesRd;

    // Flags follow the ALU on the writeback edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cReg <= 1'b0;
            zReg <= 1'b0;
            nReg <= 1'b0;
        end else if (state == stWriteback && setsFlags) begin
            cReg <= sumC;
            zReg <= sumZ;
            nReg <= sumN;
        end
    end

    // Stored carry feeds ADDC and SUBC
    assign pswC  = cReg;
    assign cFlag = cReg;
    assign zFlag = zReg;
    assign nFlag = nReg;

endmodule

/* verilog/multicycleCore.sv */
`timescale 1ns/1ps

// Core top made of control unit and datapath
module multicycleCore (
    input  logic            clk,
    input  logic            arstN,
    input  logic            instrValid,
    input  riscPkg::instr_t instrIn,
    input  riscPkg::word_t  memRdata,
    output riscPkg::word_t  memAddr,
    output riscPkg::word_t  memWdata,
    output logic            memWe,
    output riscPkg::word_t  outR,
    output logic            outValid,
    output logic            busy,
    output logic            cFlag,
    output logic            zFlag,
    output logic            nFlag
);
    import riscPkg::*;

    // Latched instruction
    instr_t instr;

    // Datapath selects
    logic rbSelRd;
    logic operandImm;
    logic liUpper;
    logic idExeLoad;
    logic useCarry;
    logic subtract;
    logic wbMem;
    logic wbLi;
    logic wbEn;
    logic pswC;

    // ALU flags back to control
    logic sumC;
    logic sumZ;
    logic sumN;

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    controlUnit uCtrl (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instrIn    (instrIn),
        .sumC       (sumC),
        .sumZ       (sumZ),
        .sumN       (sumN),
        .instr      (instr),
        .rbSelRd    (rbSelRd),
        .operandImm (operandImm),
        .liUpper    (liUpper),
        .idExeLoad  (idExeLoad),
        .useCarry   (useCarry),
        .subtract   (subtract),
        .wbMem      (wbMem),
        .wbLi       (wbLi),
        .wbEn       (wbEn),
        .pswC       (pswC),
        .busy       (busy),
        .memWe      (memWe),
        .outValid   (outValid),
        .cFlag      (cFlag),
        .zFlag      (zFlag),
        .nFlag      (nFlag)
    );

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    // ALU sum stays internal to the datapath
    rfAluDatapath uDatapath (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .rbSelRd    (rbSelRd),
        .operandImm (operandImm),
        .liUpper    (liUpper),
        .idExeLoad  (idExeLoad),
        .useCarry   (useCarry),
        .subtract   (subtract),
        .wbMem      (wbMem),
        .wbLi       (wbLi),
        .wbEn       (wbEn),
        .pswC       (pswC),
        .memRdata   (memRdata),
        .memAddr    (memAddr),
        .memWdata   (memWdata),
        .outR       (outR),
        .sum        (),
        .sumC       (sumC),
        .sumZ       (sumZ),
        .sumN       (sumN)
    );

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/1ps

// Eight general registers, two read ports, one write port
module registerFile (
    input  logic             clk,
    input  logic             arstN,
    input  logic             we,
    input  riscPkg::regAddr_t waddr,
    input  riscPkg::word_t    wdata,
    input  riscPkg::regAddr_t aAddr,
    input  riscPkg::regAddr_t bAddr,
    output riscPkg::word_t    aData,
    output riscPkg::word_t    bData
);
    import riscPkg::*;

    // Storage array
    word_t regs [numRegs];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    // All registers come up as zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Combinational reads
    // Same-cycle write shows up only after the edge
    assign aData = regs[aAddr];
    assign bData = regs[bAddr];

endmodule

/* verilog/rfAluDatapath.sv */
`timescale 1ns/1ps

// Register file, operand selection, ID/EXE registers and ALU
module rfAluDatapath (
    input  logic            clk,
    input  logic            arstN,
    input  riscPkg::instr_t instr,
    input  logic            rbSelRd,
    input  logic            operandImm,
    input  logic            liUpper,
    input  logic            idExeLoad,
    input  logic            useCarry,
    input  logic            subtract,
    input  logic            wbMem,
    input  logic            wbLi,
    input  logic            wbEn,
    input  logic            pswC,
    input  riscPkg::word_t  memRdata,
    output riscPkg::word_t  memAddr,
    output riscPkg::word_t  memWdata,
    output riscPkg::word_t  outR,
    output riscPkg::word_t  sum,
    output logic            sumC,
    output logic            sumZ,
    output logic            sumN
);
    import riscPkg::*;

    // Instruction fields
    regAddr_t rdAddr;
    regAddr_t rmAddr;
    regAddr_t rnAddr;
    logic [imm5Width-1:0] imm5;
    logic [imm8Width-1:0] imm8;

    // Register file side
    regAddr_t rbAddr;
    word_t    aData;
    word_t    bData;
    word_t    wrData;

    // Decode stage values
    word_t    aluB;
    word_t    liValue;

    // ID/EXE registers
    word_t    opA;
    word_t    opB;
    word_t    liExe;

    assign rdAddr = instr[rdMsb:rdLsb];
    assign rmAddr = instr[rmMsb:rmLsb];
    assign rnAddr = instr[rnMsb:rnLsb];
    assign imm5   = instr[imm5Width-1:0];
    assign imm8   = instr[imm8Width-1:0];

    ////////////////////////////////////////////////////////////
    // Decode stage
    ////////////////////////////////////////////////////////////

    // Port B reads rd for store data and LUI
    assign rbAddr = rbSelRd ? rdAddr : rnAddr;

    registerFile uRegFile (
        .clk   (clk),
        .arstN (arstN),
        .we    (wbEn),
        .waddr (rdAddr),
        .wdata (wrData),
        .aAddr (rmAddr),
        .bAddr (rbAddr),
        .aData (aData),
        .bData (bData)
    );

    // Zero-extended imm5 for ADDI
    assign aluB = operandImm ? {{(dataWidth-imm5Width){1'b0}}, imm5} : bData;

    // LUI keeps the low byte of rd
    assign liValue = liUpper ? {imm8, bData[imm8Width-1:0]}
                             : {{(dataWidth-imm8Width){1'b0}}, imm8};

    // Operands captured at the end of decode
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opA   <= '0;
            opB   <= '0;
            liExe <= '0;
        end else if (idExeLoad) begin
            opA   <= aData;
            opB   <= aluB;
            liExe <= liValue;
        end
    end

    ////////////////////////////////////////////////////////////
    // Execute stage
    ////////////////////////////////////////////////////////////

    aluAdder uAlu (
        .a        (opA),
        .b        (opB),
        .subtract (subtract),
        .useCarry (useCarry),
        .pswC     (pswC),
        .sum      (sum),
        .cOut     (sumC),
        .z        (sumZ),
        .n        (sumN)
    );

    // Memory address and OUT value both come from rm
    assign memAddr  = opA;
    assign outR     = opA;
    // Live read of rd during execute
    assign memWdata = bData;

    // Writeback source with memory taking priority
    always_comb begin
        if (wbMem) begin
            wrData = memRdata;
        end else if (wbLi) begin
            wrData = liExe;
        end else begin
            wrData = sum;
        end
    end

endmodule

/* verilog/riscPkg.sv */
// Shared definitions for the 16-bit multicycle core
package riscPkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Datapath width
    localparam int dataWidth = 16;
    // Register file depth
    localparam int numRegs   = 8;

    // Register value, memory data and address
    typedef logic [dataWidth-1:0] word_t;
    // Register index
    typedef logic [2:0]           regAddr_t;
    // Raw instruction word
    typedef logic [15:0]          instr_t;
    // Opcode field
    typedef logic [4:0]           opcode_t;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////

    localparam int opMsb     = 15;
    localparam int opLsb     = 11;
    localparam int rdMsb     = 10;
    localparam int rdLsb     = 8;
    localparam int rmMsb     = 7;
    localparam int rmLsb     = 5;
    localparam int rnMsb     = 4;
    localparam int rnLsb     = 2;
    // Immediates sit at the bottom of the word
    localparam int imm5Width = 5;
    localparam int imm8Width = 8;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////

    localparam opcode_t opAdd  = 5'd0;
    localparam opcode_t opAddc = 5'd1;
    localparam opcode_t opSub  = 5'd2;
    localparam opcode_t opSubc = 5'd3;
    localparam opcode_t opAddi = 5'd4;
    localparam opcode_t opCmp  = 5'd5;
    localparam opcode_t opLi   = 5'd6;
    localparam opcode_t opLui  = 5'd7;
    localparam opcode_t opLd   = 5'd8;
    localparam opcode_t opSt   = 5'd9;
    // Codes above this one act as no-ops
    localparam opcode_t opOut  = 5'd10;

    // Controller sequence for one instruction at a time
    typedef enum logic [1:0] {
        stIdle,
        stDecode,
        stExecute,
        stWriteback
    } ctrlState_t;

endpackage
